// File: Bender.yml
package:
  name: mem_game

sources:
  - rtl/memGamePkg.sv
  - rtl/memGameIfs.sv
  - rtl/pixelScan.sv
  - rtl/memGameState.sv
  - rtl/memPixelGen.sv
  - rtl/pixelColor.sv
  - rtl/memGameTop.sv
  - target: simulation
    files:
      - sim/memGameTb.sv

// File: build.f
rtl/memGamePkg.sv
rtl/memGameIfs.sv
rtl/pixelScan.sv
rtl/memGameState.sv
rtl/memPixelGen.sv
rtl/pixelColor.sv
rtl/memGameTop.sv
sim/memGameTb.sv

// File: rtl/memGameIfs.sv
`timescale 1ns/1ps

// puzzle state as seen by the pixel generator
interface memStateIf import memGamePkg::*; ();
    stage_t stage;
    digit_t [NUM_STAGES-1:0] displayNum;
    digit_t [NUM_BUTTONS-1:0][NUM_STAGES-1:0] labelNum;
    logic [1:0] memPos;  // selected button
    logic solved;

    modport source (output stage, output displayNum, output labelNum,
                    output memPos, output solved);
    modport sink (input stage, input displayNum, input labelNum,
                  input memPos, input solved);
endinterface

// classified pixel, registered together with its coordinate
interface memPixelIf import memGamePkg::*; ();
    logic displayPixel;
    logic buttonPixel;
    logic [NUM_BUTTONS-1:0] labelPixel;
    logic stagePixel;
    logic buttonHighlightPixel;
    xCoord_t pixX;
    yCoord_t pixY;

    modport source (output displayPixel, output buttonPixel, output labelPixel,
                    output stagePixel, output buttonHighlightPixel,
                    output pixX, output pixY);
    modport sink (input displayPixel, input buttonPixel, input labelPixel,
                  input stagePixel, input buttonHighlightPixel,
                  input pixX, input pixY);
endinterface

// File: rtl/memGamePkg.sv
package memGamePkg;

    // panel and button layout
    localparam int SCREEN_WIDTH = 240;
    localparam int SCREEN_HEIGHT = 240;
    localparam int BUTTON_WIDTH = 40;
    localparam int BUTTON_HEIGHT = 90;
    localparam int MARGIN_WIDTH = 25;
    localparam int MARGIN_HEIGHT = 20;
    localparam int BUTTON_SPACE = 10;
    localparam int HIGHLIGHT_PAD = 5;

    // seven-segment origins, bottom-left corner of each digit cell
    localparam int DISPLAY_ORIGIN_X = SCREEN_WIDTH - (2 * MARGIN_WIDTH + BUTTON_WIDTH);
    localparam int DISPLAY_ORIGIN_Y = 2 * MARGIN_HEIGHT + BUTTON_HEIGHT;
    localparam int LABEL_ORIGIN_Y = MARGIN_HEIGHT + 10;

    localparam int STAGE_LIGHT_Y = 218;
    localparam int STAGE_LIGHT_SIZE = 12;
    localparam int STAGE_LIGHT_X = 40;    // left edge of first light
    localparam int STAGE_LIGHT_STEP = 36; // pitch between lights

    localparam int NUM_STAGES = 5;
    localparam int NUM_BUTTONS = 4;

    typedef logic [8:0] xCoord_t;
    typedef logic [7:0] yCoord_t;
    typedef logic [1:0] digit_t;  // 0 shows "1" .. 3 shows "4"
    typedef logic [2:0] stage_t;
    typedef logic [6:0] ssdec_t;
    typedef logic [11:0] rgb_t;

    localparam ssdec_t SSDEC_ONE = 7'b0000110;
    localparam ssdec_t SSDEC_TWO = 7'b1011011;
    localparam ssdec_t SSDEC_THREE = 7'b1001111;
    localparam ssdec_t SSDEC_FOUR = 7'b1100110;

    localparam rgb_t COLOR_BG = 12'h000;
    localparam rgb_t COLOR_BUTTON = 12'h777;
    localparam rgb_t COLOR_LABEL = 12'hFFF;
    localparam rgb_t COLOR_DISPLAY = 12'h4CF;
    localparam rgb_t COLOR_HIGHLIGHT = 12'hFD0;
    localparam rgb_t COLOR_STAGE = 12'h0C0;

endpackage

// File: rtl/memGameState.sv
`timescale 1ns/1ps

module memGameState import memGamePkg::*; (
    input logic clk,
    input logic nrst,
    input logic load,
    input digit_t [NUM_STAGES-1:0] loadDisplay,
    input digit_t [NUM_BUTTONS-1:0][NUM_STAGES-1:0] loadLabels,
    input logic moveLeft,
    input logic moveRight,
    input logic press,
    input logic frameEnd,
    output logic strike,
    memStateIf.source st
);

    logic correct;
    logic lastStage;
    logic [1:0] strikeFrames;  // frame ends left before the cursor unfreezes
    logic cursorFrozen;

    // label of the selected button against the display digit, both at this stage
    assign correct = (st.labelNum[st.memPos][st.stage] == st.displayNum[st.stage]);
    assign lastStage = (st.stage == stage_t'(NUM_STAGES - 1));
    assign cursorFrozen = st.solved || (strikeFrames != 2'd0);

    always_ff @(posedge clk) begin
        if (!nrst) begin
            st.displayNum <= '0;
            st.labelNum <= '0;
            st.stage <= '0;
            st.solved <= 1'b0;
            strike <= 1'b0;
            strikeFrames <= 2'd0;
        end else begin
            strike <= 1'b0;
            if (frameEnd && strikeFrames != 2'd0) begin
                strikeFrames <= strikeFrames - 1'b1;
            end

            if (load) begin
                // new puzzle, a press in this cycle is dropped
                st.displayNum <= loadDisplay;
                st.labelNum <= loadLabels;
                st.stage <= '0;
                st.solved <= 1'b0;
            end else if (press && !st.solved) begin
                if (!correct) begin
                    strike <= 1'b1;
                    st.stage <= '0;
                    // two frame ends, so at least one whole frame shows the frozen cursor
                    strikeFrames <= 2'd2;
                end else if (lastStage) begin
                    st.solved <= 1'b1;  // stage stays on the last one
                end else begin
                    st.stage <= st.stage + 1'b1;
                end
            end
        end
    end

    // highlight cursor, saturating at both ends
    always_ff @(posedge clk) begin
        if (!nrst) begin
            st.memPos <= '0;
        end else if (!cursorFrozen) begin
            if (moveLeft && !moveRight && st.memPos != 2'd0) begin
                st.memPos <= st.memPos - 1'b1;
            end else if (moveRight && !moveLeft && st.memPos != 2'(NUM_BUTTONS - 1)) begin
                st.memPos <= st.memPos + 1'b1;
            end
        end
    end

endmodule

// File: rtl/memGameTop.sv
`timescale 1ns/1ps

module memGameTop import memGamePkg::*; (
    input logic clk,
    input logic nrst,
    input logic load,
    input digit_t [NUM_STAGES-1:0] loadDisplay,
    input digit_t [NUM_BUTTONS-1:0][NUM_STAGES-1:0] loadLabels,
    input logic moveLeft,
    input logic moveRight,
    input logic press,
    output rgb_t rgb,
    output xCoord_t outX,
    output yCoord_t outY,
    output stage_t stage,
    output logic solved,
    output logic strike
);

    xCoord_t scanX;
    yCoord_t scanY;
    logic frameEnd;

    memStateIf stateBus ();
    memPixelIf pixelBus ();

    pixelScan u_pixelScan (
        .clk      (clk),
        .nrst     (nrst),
        .x        (scanX),
        .y        (scanY),
        .frameEnd (frameEnd)
    );

    memGameState u_memGameState (
        .clk         (clk),
        .nrst        (nrst),
        .load        (load),
        .loadDisplay (loadDisplay),
        .loadLabels  (loadLabels),
        .moveLeft    (moveLeft),
        .moveRight   (moveRight),
        .press       (press),
        .frameEnd    (frameEnd),
        .strike      (strike),
        .st          (stateBus.source)
    );

    memPixelGen u_memPixelGen (
        .clk  (clk),
        .nrst (nrst),
        .x    (scanX),
        .y    (scanY),
        .st   (stateBus.sink),
        .pix  (pixelBus.source)
    );

    pixelColor u_pixelColor (
        .clk  (clk),
        .nrst (nrst),
        .pix  (pixelBus.sink),
        .rgb  (rgb),
        .outX (outX),
        .outY (outY)
    );

    // state levels straight out of the game block
    assign stage = stateBus.stage;
    assign solved = stateBus.solved;

endmodule

// File: rtl/memPixelGen.sv
`timescale 1ns/1ps

module memPixelGen import memGamePkg::*; (
    input logic clk,
    input logic nrst,
    input xCoord_t x,
    input yCoord_t y,
    memStateIf.sink st,
    memPixelIf.source pix
);

    logic displayDetect;
    logic buttonDetect;
    logic [NUM_BUTTONS-1:0] labelDetect;
    logic stageDetect;
    logic buttonHighlightDetect;
    xCoord_t hlRight;
    xCoord_t hlLeft;

    // right edge of button idx, button 0 sits at the right
    function automatic xCoord_t buttonRight(input int idx);
        return xCoord_t'(SCREEN_WIDTH - (MARGIN_WIDTH + idx * (BUTTON_WIDTH + BUTTON_SPACE)));
    endfunction

    function automatic ssdec_t digToSsdec(input digit_t digit);
        case (digit)
            2'd0: return SSDEC_ONE;
            2'd1: return SSDEC_TWO;
            2'd2: return SSDEC_THREE;
            default: return SSDEC_FOUR;
        endcase
    endfunction

    // vertical bar, 5 wide and 20 tall, tapered at the ends
    // cx is its right column and ry its top row
    function automatic logic segVert(input xCoord_t px, input yCoord_t py,
                                     input xCoord_t cx, input yCoord_t ry);
        xCoord_t dx;
        yCoord_t dy;
        dx = cx - px;  // wraps large when px is right of the bar
        dy = py - ry;
        case (dx)
            9'd0, 9'd4: return (dy >= 8'd2) && (dy <= 8'd17);
            9'd1, 9'd3: return (dy >= 8'd1) && (dy <= 8'd18);
            9'd2: return dy <= 8'd19;
            default: return 1'b0;
        endcase
    endfunction

    // horizontal bar, same shape turned sideways
    function automatic logic segHori(input xCoord_t px, input yCoord_t py,
                                     input xCoord_t cx, input yCoord_t ry);
        xCoord_t dx;
        yCoord_t dy;
        dx = cx - px;
        dy = py - ry;
        case (dy)
            8'd0, 8'd4: return (dx >= 9'd2) && (dx <= 9'd17);
            8'd1, 8'd3: return (dx >= 9'd1) && (dx <= 9'd18);
            8'd2: return dx <= 9'd19;
            default: return 1'b0;
        endcase
    endfunction

    // one digit cell with origin (ox, oy), segments g..a in bits 6..0
    function automatic logic ssdecHit(input xCoord_t px, input yCoord_t py,
                                      input xCoord_t ox, input yCoord_t oy,
                                      input ssdec_t seg);
        logic hit;
        hit = 1'b0;
        if (seg[6]) hit |= segHori(px, py, ox - 9'd10, oy + 8'd45); // middle
        if (seg[5]) hit |= segVert(px, py, ox - 9'd10, oy + 8'd45); // lower right
        if (seg[4]) hit |= segVert(px, py, ox - 9'd10, oy + 8'd25); // upper right
        if (seg[3]) hit |= segHori(px, py, ox - 9'd10, oy + 8'd25); // top
        if (seg[2]) hit |= segVert(px, py, ox - 9'd30, oy + 8'd25); // upper left
        if (seg[1]) hit |= segVert(px, py, ox - 9'd30, oy + 8'd45); // lower left
        if (seg[0]) hit |= segHori(px, py, ox - 9'd10, oy + 8'd65); // bottom
        return hit;
    endfunction

    // frame around the selected button
    assign hlRight = buttonRight(int'(st.memPos)) + xCoord_t'(HIGHLIGHT_PAD);
    assign hlLeft = buttonRight(int'(st.memPos)) - xCoord_t'(BUTTON_WIDTH + HIGHLIGHT_PAD);

    always_comb begin
        buttonDetect = 1'b0;
        stageDetect = 1'b0;

        for (int i = 0; i < NUM_BUTTONS; i++) begin
            if (x < buttonRight(i) && x > buttonRight(i) - xCoord_t'(BUTTON_WIDTH)
                && y > yCoord_t'(MARGIN_HEIGHT)
                && y < yCoord_t'(MARGIN_HEIGHT + BUTTON_HEIGHT)) begin
                buttonDetect = 1'b1;
            end
            labelDetect[i] = ssdecHit(x, y, buttonRight(i), yCoord_t'(LABEL_ORIGIN_Y),
                                      digToSsdec(st.labelNum[i][st.stage]));
        end

        displayDetect = ssdecHit(x, y, xCoord_t'(DISPLAY_ORIGIN_X),
                                 yCoord_t'(DISPLAY_ORIGIN_Y),
                                 digToSsdec(st.displayNum[st.stage]));

        buttonHighlightDetect = x < hlRight && x > hlLeft
            && y > yCoord_t'(MARGIN_HEIGHT - HIGHLIGHT_PAD)
            && y < yCoord_t'(MARGIN_HEIGHT + BUTTON_HEIGHT + HIGHLIGHT_PAD);

        // lights for cleared stages, all of them once solved
        for (int i = 0; i < NUM_STAGES; i++) begin
            if ((st.solved || stage_t'(i) < st.stage)
                && x >= xCoord_t'(STAGE_LIGHT_X + i * STAGE_LIGHT_STEP)
                && x < xCoord_t'(STAGE_LIGHT_X + i * STAGE_LIGHT_STEP + STAGE_LIGHT_SIZE)
                && y >= yCoord_t'(STAGE_LIGHT_Y)
                && y < yCoord_t'(STAGE_LIGHT_Y + STAGE_LIGHT_SIZE)) begin
                stageDetect = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!nrst) begin
            pix.displayPixel <= 1'b0;
            pix.buttonPixel <= 1'b0;
            pix.labelPixel <= '0;
            pix.stagePixel <= 1'b0;
            pix.buttonHighlightPixel <= 1'b0;
            pix.pixX <= '0;
            pix.pixY <= '0;
        end else begin
            pix.displayPixel <= displayDetect;
            pix.buttonPixel <= buttonDetect;
            pix.labelPixel <= labelDetect;
            pix.stagePixel <= stageDetect;
            pix.buttonHighlightPixel <= buttonHighlightDetect;
            pix.pixX <= x;  // coordinate travels with its flags
            pix.pixY <= y;
        end
    end

endmodule

// File: rtl/pixelColor.sv
`timescale 1ns/1ps

module pixelColor import memGamePkg::*; (
    input logic clk,
    input logic nrst,
    memPixelIf.sink pix,
    output rgb_t rgb,
    output xCoord_t outX,
    output yCoord_t outY
);

    rgb_t color;

    // topmost element wins
    always_comb begin
        if (|pix.labelPixel) begin
            color = COLOR_LABEL;
        end else if (pix.displayPixel) begin
            color = COLOR_DISPLAY;
        end else if (pix.stagePixel) begin
            color = COLOR_STAGE;
        end else if (pix.buttonPixel) begin
            color = COLOR_BUTTON;
        end else if (pix.buttonHighlightPixel) begin
            color = COLOR_HIGHLIGHT;  // only the rim outside the button body
        end else begin
            color = COLOR_BG;
        end
    end

    always_ff @(posedge clk) begin
        if (!nrst) begin
            rgb <= '0;
            outX <= '0;
            outY <= '0;
        end else begin
            rgb <= color;
            outX <= pix.pixX;
            outY <= pix.pixY;
        end
    end

endmodule

// File: rtl/pixelScan.sv
`timescale 1ns/1ps

module pixelScan import memGamePkg::*; (
    input logic clk,
    input logic nrst,
    output xCoord_t x,
    output yCoord_t y,
    output logic frameEnd
);

    logic lastX;
    logic lastY;

    assign lastX = (x == xCoord_t'(SCREEN_WIDTH - 1));
    assign lastY = (y == yCoord_t'(SCREEN_HEIGHT - 1));

    // one pixel per cycle, row by row
    always_ff @(posedge clk) begin
        if (!nrst) begin
            x <= '0;
            y <= '0;
        end else if (lastX) begin
            x <= '0;
            if (lastY) begin
                y <= '0;
            end else begin
                y <= y + 1'b1;
            end
        end else begin
            x <= x + 1'b1;
        end
    end

    assign frameEnd = lastX && lastY;  // last pixel of the frame

endmodule

// File: sim/memGameTb.sv
`timescale 1ns/1ps

module memGameTb import memGamePkg::*; ();

    localparam int FRAME_CYCLES = SCREEN_WIDTH * SCREEN_HEIGHT;
    localparam int CYCLE_LIMIT = FRAME_CYCLES * 6 * 11 / 10;  // six frames and 10 percent

    // game state as the pixel generator sees it
    typedef struct packed {
        stage_t stage;
        logic solved;
        logic [1:0] memPos;
        digit_t [NUM_STAGES-1:0] disp;
        digit_t [NUM_BUTTONS-1:0][NUM_STAGES-1:0] labels;
    } gameView_t;

    logic clk, nrst, load, moveLeft, moveRight, press;
    digit_t [NUM_STAGES-1:0] loadDisplay;
    digit_t [NUM_BUTTONS-1:0][NUM_STAGES-1:0] loadLabels;
    rgb_t rgb;
    xCoord_t outX;
    yCoord_t outY;
    stage_t stage;
    logic solved, strike;

    gameView_t view, viewD1, viewD2;  // model now and one and two edges back
    logic strikeExp;
    logic started;
    int strikeFrames;
    int scanX, scanY, expX1, expY1, expX2, expY2;
    int cycleCount;
    logic [31:0] lcgState;

    memGameTop u_memGameTop (
        .clk         (clk),
        .nrst        (nrst),
        .load        (load),
        .loadDisplay (loadDisplay),
        .loadLabels  (loadLabels),
        .moveLeft    (moveLeft),
        .moveRight   (moveRight),
        .press       (press),
        .rgb         (rgb),
        .outX        (outX),
        .outY        (outY),
        .stage       (stage),
        .solved      (solved),
        .strike      (strike)
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] nextRand();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState >> 16;  // upper half of the state
    endfunction

    // tapered bar 5 wide and 20 long with ends cut back one pixel per step off the centre line
    function automatic logic barHit(input int across, input int along);
        int a;
        a = (across < 0) ? -across : across;
        return a <= 2 && along >= a && along <= 19 - a;
    endfunction

    // digit cell with its corner at (ox, oy) and segment k on pattern bit k
    function automatic logic digitLit(input int px, input int py, input int ox, input int oy,
                                      input digit_t d);
        ssdec_t seg;
        logic lit;
        int k;
        int cx;
        int ry;
        case (d)
            2'd0: seg = SSDEC_ONE;
            2'd1: seg = SSDEC_TWO;
            2'd2: seg = SSDEC_THREE;
            default: seg = SSDEC_FOUR;
        endcase
        lit = 1'b0;
        for (k = 0; k < 7; k++) begin
            cx = (k == 1 || k == 2) ? ox - 30 : ox - 10;  // left or right column
            ry = (k == 0) ? oy + 65 : (k == 1 || k == 5 || k == 6) ? oy + 45 : oy + 25;
            if (seg[k] && (k == 0 || k == 3 || k == 6)) begin
                lit |= barHit(py - (ry + 2), cx - px);
            end else if (seg[k]) begin
                lit |= barHit(px - (cx - 2), py - ry);
            end
        end
        return lit;
    endfunction

    function automatic rgb_t expectColor(input int px, input int py, input gameView_t v);
        logic label, disp, light, body, frame;
        int right;
        int b;
        int s;
        {label, light, body, frame} = 4'b0000;
        for (b = 0; b < NUM_BUTTONS; b++) begin
            right = SCREEN_WIDTH - MARGIN_WIDTH - b * (BUTTON_WIDTH + BUTTON_SPACE);
            body |= px > right - BUTTON_WIDTH && px < right
                && py > MARGIN_HEIGHT && py < MARGIN_HEIGHT + BUTTON_HEIGHT;
            frame |= b == v.memPos && px > right - BUTTON_WIDTH - HIGHLIGHT_PAD
                && px < right + HIGHLIGHT_PAD && py > MARGIN_HEIGHT - HIGHLIGHT_PAD
                && py < MARGIN_HEIGHT + BUTTON_HEIGHT + HIGHLIGHT_PAD;
            label |= digitLit(px, py, right, MARGIN_HEIGHT + 10, v.labels[b][v.stage]);
        end
        disp = digitLit(px, py, SCREEN_WIDTH - 2 * MARGIN_WIDTH - BUTTON_WIDTH,
                        2 * MARGIN_HEIGHT + BUTTON_HEIGHT, v.disp[v.stage]);
        for (s = 0; s < NUM_STAGES; s++) begin
            light |= (v.solved || s < v.stage)
                && px >= STAGE_LIGHT_X + s * STAGE_LIGHT_STEP
                && px < STAGE_LIGHT_X + s * STAGE_LIGHT_STEP + STAGE_LIGHT_SIZE
                && py >= STAGE_LIGHT_Y && py < STAGE_LIGHT_Y + STAGE_LIGHT_SIZE;
        end
        if (label) return COLOR_LABEL;
        if (disp) return COLOR_DISPLAY;
        if (light) return COLOR_STAGE;
        if (body) return COLOR_BUTTON;
        if (frame) return COLOR_HIGHLIGHT;
        return COLOR_BG;
    endfunction

    // button whose label at this stage matches the display digit
    function automatic int targetButton();
        int b;
        int hit;
        hit = 0;
        for (b = 0; b < NUM_BUTTONS; b++) begin
            if (view.labels[b][view.stage] == view.disp[view.stage]) hit = b;
        end
        return hit;
    endfunction

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp) begin
            $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
            $display("STATUS: FAIL");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    // model of the game rules and the two-stage pixel pipe
    always @(posedge clk) begin
        logic frozen;
        started = 1'b1;
        viewD2 = viewD1;
        viewD1 = view;
        {expX2, expY2, expX1, expY1} = {expX1, expY1, scanX, scanY};
        frozen = view.solved || strikeFrames != 0;
        strikeExp = 1'b0;
        if (!nrst) begin
            view = '0;
            strikeFrames = 0;
            scanX = 0;
            scanY = 0;
        end else begin
            if (scanX == SCREEN_WIDTH - 1 && scanY == SCREEN_HEIGHT - 1 && strikeFrames != 0)
                strikeFrames--;
            if (load) begin
                view.disp = loadDisplay;
                view.labels = loadLabels;
                view.stage = '0;
                view.solved = 1'b0;
            end else if (press && !view.solved) begin
                if (view.labels[view.memPos][view.stage] != view.disp[view.stage]) begin
                    strikeExp = 1'b1;
                    view.stage = '0;
                    strikeFrames = 2;  // cursor holds for two frame ends
                end else if (view.stage == NUM_STAGES - 1) begin
                    view.solved = 1'b1;
                end else begin
                    view.stage = view.stage + 1'b1;
                end
            end
            if (!frozen && moveRight && !moveLeft && view.memPos != NUM_BUTTONS - 1)
                view.memPos = view.memPos + 1'b1;
            else if (!frozen && moveLeft && !moveRight && view.memPos != 0)
                view.memPos = view.memPos - 1'b1;
            scanY = (scanX == SCREEN_WIDTH - 1) ? (scanY + 1) % SCREEN_HEIGHT : scanY;
            scanX = (scanX + 1) % SCREEN_WIDTH;
        end
    end

    always @(negedge clk) begin
        if (started) begin
            checkValue("outX", outX, expX2);
            checkValue("outY", outY, expY2);
            checkValue("rgb", rgb, expectColor(expX2, expY2, viewD2));
            checkValue("stage", stage, view.stage);
            checkValue("solved", solved, view.solved);
            checkValue("strike", strike, strikeExp);
        end
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount > CYCLE_LIMIT) begin
            $display("Timeout: test sequence still running after %0d cycles", CYCLE_LIMIT);
            $display("STATUS: FAIL");
            $fatal(1, "cycle limit reached");
        end
    end

    task automatic waitOut(input int x, input int y);
        @(negedge clk);
        while (!(outX == x && outY == y)) @(negedge clk);
    endtask

    task automatic stepCursor(input bit right);
        @(posedge clk);
        #2;
        moveRight = right;
        moveLeft = !right;
        @(posedge clk);
        #2;
        moveRight = 1'b0;
        moveLeft = 1'b0;
    endtask

    task automatic moveCursor(input int btn);
        while (view.memPos != btn) stepCursor(btn > view.memPos);
    endtask

    task automatic pressAt(input int btn);
        moveCursor(btn);
        @(posedge clk);
        #2;
        press = 1'b1;
        @(posedge clk);
        #2;
        press = 1'b0;
    endtask

    // random display digits with each stage's labels a shuffle of all four digits
    task automatic loadPuzzle(input logic withPress);
        int perm[NUM_BUTTONS];
        int s;
        int i;
        int j;
        int tmp;
        @(posedge clk);
        #2;
        for (s = 0; s < NUM_STAGES; s++) begin
            loadDisplay[s] = digit_t'(nextRand());
            for (i = 0; i < NUM_BUTTONS; i++) perm[i] = i;
            for (i = NUM_BUTTONS - 1; i > 0; i--) begin
                j = nextRand() % (i + 1);
                tmp = perm[i];
                perm[i] = perm[j];
                perm[j] = tmp;
            end
            for (i = 0; i < NUM_BUTTONS; i++) loadLabels[i][s] = digit_t'(perm[i]);
        end
        load = 1'b1;
        press = withPress;
        @(posedge clk);
        #2;
        load = 1'b0;
        press = 1'b0;
    endtask

    initial begin
        int i;
        {clk, nrst, load, moveLeft, moveRight, press} = 6'b0;
        loadDisplay = '0;
        loadLabels = '0;
        {view, viewD1, viewD2} = '0;
        {strikeExp, started} = 2'b00;
        {strikeFrames, scanX, scanY, expX1, expY1, expX2, expY2} = '0;
        cycleCount = 0;
        lcgState = 32'h226f1994;
        repeat (8) @(posedge clk);
        #2;
        nrst = 1'b1;
        waitOut(SCREEN_WIDTH - 1, SCREEN_HEIGHT - 1);  // first screen before any puzzle

        loadPuzzle(1'b0);
        for (i = 0; i < 4; i++) begin
            waitOut(0, 30 + 20 * i);  // inside the highlight rows
            stepCursor(1'b1);  // the fourth one saturates
        end
        waitOut(SCREEN_WIDTH - 1, SCREEN_HEIGHT - 1);
        stepCursor(1'b0);
        waitOut(SCREEN_WIDTH - 1, SCREEN_HEIGHT - 1);

        for (i = 0; i < NUM_STAGES; i++) begin
            waitOut(0, 30 + 50 * i);  // the last one below the stage light rows
            pressAt(targetButton());
        end
        checkValue("solved", solved, 1);
        checkValue("stage", stage, NUM_STAGES - 1);
        waitOut(0, 100);
        stepCursor(view.memPos == 0);  // ignored once solved
        waitOut(SCREEN_WIDTH - 1, SCREEN_HEIGHT - 1);

        loadPuzzle(1'b0);
        waitOut(0, 30);
        pressAt(targetButton());
        waitOut(0, 40);
        pressAt(targetButton());
        checkValue("stage", stage, 2);
        waitOut(0, 50);
        moveCursor((targetButton() + 1) % NUM_BUTTONS);  // a press here strikes the old puzzle
        loadPuzzle(1'b1);  // press in the load cycle is dropped
        checkValue("stage", stage, 0);
        waitOut(0, 140);
        pressAt(targetButton());
        waitOut(0, 180);
        pressAt((targetButton() + 1) % NUM_BUTTONS);
        checkValue("strike", strike, 1);
        checkValue("stage", stage, 0);
        @(posedge clk);
        #2;
        checkValue("strike", strike, 0);
        waitOut(SCREEN_WIDTH - 1, SCREEN_HEIGHT - 1);

        $display("STATUS: PASS");
        $finish;
    end

endmodule
